/* sim.f */
+incdir+testbench
rtl/qctx_pkg.sv
rtl/queue_table_ram.sv
rtl/port_b_arbiter.sv
rtl/queue_switch_fsm.sv
rtl/status_regs.sv
rtl/queue_ctx_top.sv
testbench/tb_queue_ctx.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_queue_ctx -f sim.f -o tb_queue_ctx &&
out=$(./obj_dir/tb_queue_ctx) &&
echo "$out" &&
echo "$out" | grep -qx "Test OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* testbench/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// expected table contents, indexed by queue and field
reg_word_t model_tbl [2**APP_IDX_WIDTH][NUM_TABLES];
reg_word_t model_ctrl;
logic [15:0] lfsr_state;

// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
function automatic reg_word_t rand_bits(input int nbits);
    reg_word_t r;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
        r = {r[30:0], lfsr_state[0]};
        if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 16'hb400;
        end else begin
            lfsr_state = lfsr_state >> 1;
        end
    end
    return r;
endfunction

function automatic logic [PCIE_DWIDTH-1:0] rand_line();
    logic [PCIE_DWIDTH-1:0] line;
    for (int i = 0; i < REG_LANES; i++) begin
        line[32*i +: 32] = rand_bits(32);
    end
    return line;
endfunction

// about half the lanes fully enabled, the rest random nibbles
function automatic logic [PCIE_DWIDTH/8-1:0] rand_be();
    logic [PCIE_DWIDTH/8-1:0] be;
    for (int i = 0; i < REG_LANES; i++) begin
        if (rand_bits(1) != '0) begin
            be[4*i +: 4] = 4'hf;
        end else begin
            be[4*i +: 4] = 4'(rand_bits(4));
        end
    end
    return be;
endfunction

// a field changes only when all four bytes of its lane are enabled
function automatic void model_write(input queue_idx_t q, input logic [PCIE_DWIDTH-1:0] data,
                                    input logic [PCIE_DWIDTH/8-1:0] be);
    for (int i = 0; i < NUM_TABLES; i++) begin
        if (&be[4*i +: 4]) begin
            model_tbl[q][i] = data[32*i +: 32];
        end
    end
endfunction

function automatic logic [127:0] expected_row(input queue_idx_t q);
    return {model_tbl[q][3], model_tbl[q][2], model_tbl[q][1], model_tbl[q][0]};
endfunction

function automatic queue_ctx_t expected_ctx(input queue_idx_t q);
    queue_ctx_t c;
    c.tail = model_tbl[q][0];
    c.head = model_tbl[q][1];
    c.kmem_addr = {model_tbl[q][3], model_tbl[q][2]};
    return c;
endfunction

// word 0 is the control register, word n maps to entry n-1
function automatic reg_word_t expected_status(input logic [STAT_ADDR_WIDTH-1:0] word);
    logic [STAT_ADDR_WIDTH-1:0] idx;
    idx = word - 1'b1;
    if (word == STAT_ADDR_WIDTH'(CTRL_ADDR)) begin
        return model_ctrl;
    end
    return model_tbl[idx[2 +: APP_IDX_WIDTH]][idx[1:0]];
endfunction

`endif

/* testbench/tb_queue_ctx.sv */
module tb_queue_ctx
    import qctx_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int PCIE_ADDR_WIDTH = 16;
localparam int NUM_QUEUES = 2 ** APP_IDX_WIDTH;
// longest wait for any response, in cycles
localparam int WAIT_LIMIT = 40;

logic pcie_clk;
logic pcie_reset_n;
logic [PCIE_ADDR_WIDTH-1:0] pcie_address;
logic pcie_write;
logic pcie_read;
logic [PCIE_DWIDTH-1:0] pcie_writedata;
logic [PCIE_DWIDTH/8-1:0] pcie_byteenable;
logic [PCIE_DWIDTH-1:0] pcie_readdata;
logic pcie_readdatavalid;
logic [STAT_ADDR_WIDTH-1:0] status_addr;
logic status_read;
logic status_write;
reg_word_t status_writedata;
reg_word_t status_readdata;
logic status_readdata_valid;
logic dma_start;
queue_idx_t dma_queue;
logic dma_done;
reg_word_t new_tail;
logic queue_ready;
queue_ctx_t f2c_ctx;
logic disable_pcie;
logic [RB_SIZE_WIDTH-1:0] rb_size;

int errors;
int checks;
// -1 while no queue is loaded
int active_q;
logic [127:0] exp_rows [$];
reg_word_t exp_words [$];

`include "tb_model.svh"

queue_ctx_top #(.PCIE_ADDR_WIDTH(PCIE_ADDR_WIDTH)) uut (.*);

initial begin
    pcie_clk = 1'b0;
    forever begin
        #10 pcie_clk = ~pcie_clk;
    end
end

task automatic check_word(input string name, input reg_word_t got, input reg_word_t want);
    checks++;
    if (got !== want) begin
        errors++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, want);
    end
endtask

task automatic check_row(input string name, input logic [127:0] got, input logic [127:0] want);
    checks++;
    if (got !== want) begin
        errors++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, want);
    end
endtask

task automatic check_ctx(input string name, input queue_ctx_t got, input queue_ctx_t want);
    checks++;
    if (got !== want) begin
        errors++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, want);
    end
endtask

task automatic host_write(input queue_idx_t q, input logic [PCIE_DWIDTH-1:0] data,
                          input logic [PCIE_DWIDTH/8-1:0] be);
    pcie_address = PCIE_ADDR_WIDTH'(q) << PAGE_LSB;
    pcie_writedata = data;
    pcie_byteenable = be;
    pcie_write = 1'b1;
    model_write(q, data, be);
    @(negedge pcie_clk);
    pcie_write = 1'b0;
endtask

task automatic host_read(input queue_idx_t q);
    int n;
    exp_rows.push_back(expected_row(q));
    pcie_address = PCIE_ADDR_WIDTH'(q) << PAGE_LSB;
    pcie_read = 1'b1;
    @(negedge pcie_clk);
    pcie_read = 1'b0;
    n = 1;
    while (!pcie_readdatavalid && n < WAIT_LIMIT) begin
        @(negedge pcie_clk);
        n++;
    end
    if (!pcie_readdatavalid) begin
        $display("no host read data for queue %0d within %0d cycles", q, WAIT_LIMIT);
        errors++;
        exp_rows.delete();
    end
    @(negedge pcie_clk);
endtask

task automatic wait_status_data();
    int n;
    n = 0;
    while (!status_readdata_valid && n < WAIT_LIMIT) begin
        @(negedge pcie_clk);
        n++;
    end
    if (!status_readdata_valid) begin
        $display("no status read data for word %0d within %0d cycles", status_addr, WAIT_LIMIT);
        errors++;
        exp_words.delete();
    end
    @(negedge pcie_clk);
endtask

task automatic status_write_word(input logic [STAT_ADDR_WIDTH-1:0] word, input reg_word_t data);
    status_addr = word;
    status_writedata = data;
    status_write = 1'b1;
    if (word == STAT_ADDR_WIDTH'(CTRL_ADDR)) begin
        model_ctrl = data;
    end
    @(negedge pcie_clk);
    status_write = 1'b0;
endtask

task automatic status_read_word(input logic [STAT_ADDR_WIDTH-1:0] word);
    exp_words.push_back(expected_status(word));
    status_addr = word;
    status_read = 1'b1;
    @(negedge pcie_clk);
    status_read = 1'b0;
    wait_status_data();
endtask

// host writes to the neighbour queue keep port B busy meanwhile
task automatic status_read_busy(input logic [STAT_ADDR_WIDTH-1:0] word);
    queue_idx_t wq;
    wq = queue_idx_t'((word - 1) >> 2) ^ queue_idx_t'(1);
    exp_words.push_back(expected_status(word));
    status_addr = word;
    status_read = 1'b1;
    host_write(wq, rand_line(), '1);
    status_read = 1'b0;
    repeat (3) begin
        host_write(wq, rand_line(), rand_be());
    end
    wait_status_data();
endtask

task automatic dma_begin(input queue_idx_t q);
    int n;
    int want_lat;
    want_lat = (active_q == int'(q)) ? 1 : 4;
    dma_queue = q;
    dma_start = 1'b1;
    @(negedge pcie_clk);
    dma_start = 1'b0;
    n = 1;
    while (!queue_ready && n < WAIT_LIMIT) begin
        @(negedge pcie_clk);
        n++;
    end
    if (!queue_ready) begin
        $display("queue_ready for queue %0d never came", q);
        errors++;
    end else begin
        if (n != want_lat) begin
            $display("queue_ready for queue %0d after %0d cycles, not %0d", q, n, want_lat);
            errors++;
        end
        check_ctx("f2c_ctx", f2c_ctx, expected_ctx(q));
    end
    active_q = int'(q);
    @(negedge pcie_clk);
    check_word("queue_ready", reg_word_t'(queue_ready), '0);
endtask

task automatic dma_finish(input reg_word_t tail);
    new_tail = tail;
    dma_done = 1'b1;
    @(negedge pcie_clk);
    dma_done = 1'b0;
    model_tbl[active_q][0] = tail;
    check_ctx("f2c_ctx", f2c_ctx, expected_ctx(queue_idx_t'(active_q)));
endtask

// read data is compared here as it arrives
initial begin : compare_results
    logic [127:0] row;
    reg_word_t word;
    forever begin
        @(negedge pcie_clk);
        if (pcie_readdatavalid) begin
            if (exp_rows.size() == 0) begin
                $display("host read data at %0t with no read outstanding", $time);
                errors++;
            end else begin
                row = exp_rows.pop_front();
                check_row("pcie_readdata", pcie_readdata[127:0], row);
                for (int i = NUM_TABLES; i < REG_LANES; i++) begin
                    check_word("pcie_readdata upper lane", pcie_readdata[32*i +: 32], '0);
                end
            end
        end
        if (status_readdata_valid) begin
            if (exp_words.size() == 0) begin
                $display("status read data at %0t with no read outstanding", $time);
                errors++;
            end else begin
                word = exp_words.pop_front();
                check_word("status_readdata", status_readdata, word);
            end
        end
    end
end

initial begin : stimulus
    queue_idx_t qa;
    logic [STAT_ADDR_WIDTH-1:0] word;

    pcie_reset_n = 1'b0;
    pcie_address = '0;
    pcie_write = 1'b0;
    pcie_read = 1'b0;
    pcie_writedata = '0;
    pcie_byteenable = '0;
    status_addr = '0;
    status_read = 1'b0;
    status_write = 1'b0;
    status_writedata = '0;
    dma_start = 1'b0;
    dma_queue = '0;
    dma_done = 1'b0;
    new_tail = '0;
    lfsr_state = 16'd16395;
    model_ctrl = '0;
    errors = 0;
    checks = 0;
    active_q = -1;

    repeat (16) @(negedge pcie_clk);
    pcie_reset_n = 1'b1;
    @(negedge pcie_clk);
    check_word("queue_ready", reg_word_t'(queue_ready), '0);
    check_word("pcie_readdatavalid", reg_word_t'(pcie_readdatavalid), '0);
    check_word("status_readdata_valid", reg_word_t'(status_readdata_valid), '0);
    check_word("disable_pcie", reg_word_t'(disable_pcie), '0);
    check_word("rb_size", reg_word_t'(rb_size), '0);

    // fill every queue with all lanes enabled
    for (int q = 0; q < NUM_QUEUES; q++) begin
        host_write(queue_idx_t'(q), rand_line(), '1);
    end
    for (int q = 0; q < NUM_QUEUES; q++) begin
        host_read(queue_idx_t'(q));
    end

    // partial byte enables
    repeat (24) begin
        host_write(queue_idx_t'(rand_bits(APP_IDX_WIDTH)), rand_line(), rand_be());
    end
    for (int q = 0; q < NUM_QUEUES; q++) begin
        host_read(queue_idx_t'(q));
    end

    // control register
    repeat (3) begin
        status_write_word(STAT_ADDR_WIDTH'(CTRL_ADDR), rand_bits(32));
        status_read_word(STAT_ADDR_WIDTH'(CTRL_ADDR));
        check_word("disable_pcie", reg_word_t'(disable_pcie), reg_word_t'(model_ctrl[DISABLE_BIT]));
        check_word("rb_size", reg_word_t'(rb_size),
                   reg_word_t'(model_ctrl[RB_SIZE_LSB +: RB_SIZE_WIDTH]));
    end

    // table fields over the status bus, idle and then behind host writes
    repeat (16) begin
        word = STAT_ADDR_WIDTH'(rand_bits(6) + 1);
        status_read_word(word);
    end
    repeat (6) begin
        word = STAT_ADDR_WIDTH'(rand_bits(6) + 1);
        status_read_busy(word);
    end

    // queue switch, tail write-back, then a restart of the same queue
    qa = queue_idx_t'(rand_bits(APP_IDX_WIDTH));
    dma_begin(qa);
    dma_finish(rand_bits(32));
    host_read(qa);
    dma_begin(qa);
    host_write(qa, rand_line(), rand_be());
    check_ctx("f2c_ctx", f2c_ctx, expected_ctx(qa));
    dma_finish(rand_bits(32));
    dma_begin(qa ^ queue_idx_t'(5));
    dma_finish(rand_bits(32));
    for (int q = 0; q < NUM_QUEUES; q++) begin
        host_read(queue_idx_t'(q));
    end

    repeat (4) @(negedge pcie_clk);
    if (exp_rows.size() != 0 || exp_words.size() != 0) begin
        $display("%0d host and %0d status reads never returned data",
                 exp_rows.size(), exp_words.size());
        errors++;
    end
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("Test OK");
    end else begin
        $display("Test FAILED");
    end
    $finish;
end

endmodule

/* rtl/queue_ctx_top.sv */
module queue_ctx_top
    import qctx_pkg::*;
#(
    parameter int PCIE_ADDR_WIDTH = 16
) (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,

    // host port 0
    input  logic [PCIE_ADDR_WIDTH-1:0] pcie_address,
    input  logic                       pcie_write,
    input  logic                       pcie_read,
    input  logic [PCIE_DWIDTH-1:0]     pcie_writedata,
    input  logic [PCIE_DWIDTH/8-1:0]   pcie_byteenable,
    output logic [PCIE_DWIDTH-1:0]     pcie_readdata,
    output logic                       pcie_readdatavalid,

    // status bus
    input  logic [STAT_ADDR_WIDTH-1:0] status_addr,
    input  logic                       status_read,
    input  logic                       status_write,
    input  reg_word_t                  status_writedata,
    output reg_word_t                  status_readdata,
    output logic                       status_readdata_valid,

    // DMA side
    input  logic                       dma_start,
    input  queue_idx_t                 dma_queue,
    input  logic                       dma_done,
    input  reg_word_t                  new_tail,
    output logic                       queue_ready,
    output queue_ctx_t                 f2c_ctx,

    output logic                       disable_pcie,
    output logic [RB_SIZE_WIDTH-1:0]   rb_size
);

localparam int DEPTH = 2 ** APP_IDX_WIDTH;

logic stat_rd_req;
table_sel_t stat_rd_sel;
queue_idx_t stat_rd_queue;
reg_word_t stat_rd_data;
logic stat_rd_valid;

table_wr_t [NUM_TABLES-1:0] wr_b;
logic [NUM_TABLES-1:0] rd_en_b;
queue_idx_t rd_addr_b;
reg_word_t [NUM_TABLES-1:0] rd_data_b;

queue_idx_t addr_a;
logic [NUM_TABLES-1:0] rd_en_a;
logic wr_en_a;
reg_word_t wr_data_a;
reg_word_t [NUM_TABLES-1:0] rd_data_a;

status_regs u_status_regs (
    .pcie_clk, .pcie_reset_n,
    .status_addr, .status_read, .status_write, .status_writedata,
    .status_readdata, .status_readdata_valid,
    .stat_rd_req, .stat_rd_sel, .stat_rd_queue, .stat_rd_data, .stat_rd_valid,
    .disable_pcie, .rb_size
);

port_b_arbiter #(.PCIE_ADDR_WIDTH(PCIE_ADDR_WIDTH)) u_port_b_arbiter (
    .pcie_clk, .pcie_reset_n,
    .pcie_address, .pcie_write, .pcie_read, .pcie_writedata, .pcie_byteenable,
    .pcie_readdata, .pcie_readdatavalid,
    .stat_rd_req, .stat_rd_sel, .stat_rd_queue, .stat_rd_data, .stat_rd_valid,
    .wr_b, .rd_en_b, .rd_addr_b, .rd_data_b
);

queue_switch_fsm #(.PCIE_ADDR_WIDTH(PCIE_ADDR_WIDTH)) u_queue_switch_fsm (
    .pcie_clk, .pcie_reset_n,
    .pcie_address, .pcie_write, .pcie_writedata, .pcie_byteenable, .wr_b,
    .dma_start, .dma_queue, .dma_done, .new_tail, .queue_ready, .f2c_ctx,
    .addr_a, .rd_en_a, .wr_en_a, .wr_data_a, .rd_data_a
);

// only the tail table is written back through port A
queue_table_ram #(.DEPTH(DEPTH)) q_tails (
    .pcie_clk, .addr_a, .rd_en_a(rd_en_a[TBL_TAIL]), .wr_en_a, .wr_data_a,
    .rd_data_a(rd_data_a[TBL_TAIL]), .wr_b(wr_b[TBL_TAIL]), .rd_en_b(rd_en_b[TBL_TAIL]),
    .rd_addr_b, .rd_data_b(rd_data_b[TBL_TAIL])
);

queue_table_ram #(.DEPTH(DEPTH)) q_heads (
    .pcie_clk, .addr_a, .rd_en_a(rd_en_a[TBL_HEAD]), .wr_en_a(1'b0), .wr_data_a,
    .rd_data_a(rd_data_a[TBL_HEAD]), .wr_b(wr_b[TBL_HEAD]), .rd_en_b(rd_en_b[TBL_HEAD]),
    .rd_addr_b, .rd_data_b(rd_data_b[TBL_HEAD])
);

queue_table_ram #(.DEPTH(DEPTH)) q_kmem_lo (
    .pcie_clk, .addr_a, .rd_en_a(rd_en_a[TBL_KMEM_LO]), .wr_en_a(1'b0), .wr_data_a,
    .rd_data_a(rd_data_a[TBL_KMEM_LO]), .wr_b(wr_b[TBL_KMEM_LO]),
    .rd_en_b(rd_en_b[TBL_KMEM_LO]), .rd_addr_b, .rd_data_b(rd_data_b[TBL_KMEM_LO])
);

queue_table_ram #(.DEPTH(DEPTH)) q_kmem_hi (
    .pcie_clk, .addr_a, .rd_en_a(rd_en_a[TBL_KMEM_HI]), .wr_en_a(1'b0), .wr_data_a,
    .rd_data_a(rd_data_a[TBL_KMEM_HI]), .wr_b(wr_b[TBL_KMEM_HI]),
    .rd_en_b(rd_en_b[TBL_KMEM_HI]), .rd_addr_b, .rd_data_b(rd_data_b[TBL_KMEM_HI])
);

endmodule

/* rtl/status_regs.sv */
module status_regs
    import qctx_pkg::*;
(
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,

    // status bus
    input  logic [STAT_ADDR_WIDTH-1:0] status_addr,
    input  logic                       status_read,
    input  logic                       status_write,
    input  reg_word_t                  status_writedata,
    output reg_word_t                  status_readdata,
    output logic                       status_readdata_valid,

    // table field reads through the arbiter
    output logic                       stat_rd_req,
    output table_sel_t                 stat_rd_sel,
    output queue_idx_t                 stat_rd_queue,
    input  reg_word_t                  stat_rd_data,
    input  logic                       stat_rd_valid,

    output logic                       disable_pcie,
    output logic [RB_SIZE_WIDTH-1:0]   rb_size
);

reg_word_t control_reg;
logic is_ctrl;
// word n maps to table entry n-1
logic [STAT_ADDR_WIDTH-1:0] word_idx;

assign is_ctrl = status_addr == STAT_ADDR_WIDTH'(CTRL_ADDR);
assign word_idx = status_addr - 1'b1;

always_ff @(posedge pcie_clk) begin
    stat_rd_req <= 1'b0;
    status_readdata_valid <= 1'b0;

    if (!pcie_reset_n) begin
        control_reg <= '0;
    end else begin
        if (status_write && is_ctrl) begin
            control_reg <= status_writedata;
        end

        if (status_read && is_ctrl) begin
            status_readdata <= control_reg;
            status_readdata_valid <= 1'b1;
        end else if (status_read) begin
            stat_rd_req <= 1'b1;
            stat_rd_sel <= table_sel_t'(word_idx[1:0]);
            stat_rd_queue <= word_idx[2 +: APP_IDX_WIDTH];
        end

        if (stat_rd_valid) begin
            status_readdata <= stat_rd_data;
            status_readdata_valid <= 1'b1;
        end
    end
end

assign disable_pcie = control_reg[DISABLE_BIT];
assign rb_size = control_reg[RB_SIZE_LSB +: RB_SIZE_WIDTH];

endmodule

/* rtl/queue_switch_fsm.sv */
module queue_switch_fsm
    import qctx_pkg::*;
#(
    parameter int PCIE_ADDR_WIDTH = 16
) (
    input  logic                         pcie_clk,
    input  logic                         pcie_reset_n,

    // host writes, watched for interception
    input  logic [PCIE_ADDR_WIDTH-1:0]   pcie_address,
    input  logic                         pcie_write,
    input  logic [PCIE_DWIDTH-1:0]       pcie_writedata,
    input  logic [PCIE_DWIDTH/8-1:0]     pcie_byteenable,
    input  table_wr_t [NUM_TABLES-1:0]   wr_b,

    // DMA side
    input  logic                         dma_start,
    input  queue_idx_t                   dma_queue,
    input  logic                         dma_done,
    input  reg_word_t                    new_tail,
    output logic                         queue_ready,
    output queue_ctx_t                   f2c_ctx,

    // port A of the four tables
    output queue_idx_t                   addr_a,
    output logic [NUM_TABLES-1:0]        rd_en_a,
    output logic                         wr_en_a,
    output reg_word_t                    wr_data_a,
    input  reg_word_t [NUM_TABLES-1:0]   rd_data_a
);

typedef enum logic [2:0] {
    IDLE,
    BRAM_DELAY_1,
    BRAM_DELAY_2,
    SWITCH_QUEUE,
    WAIT_DMA
} state_t;

state_t state;
// extra msb marks no active queue
logic [APP_IDX_WIDTH:0] queue_id;
// fields still expected from the table
logic [NUM_TABLES-1:0] load_pend;
logic [APP_IDX_WIDTH:0] hit_queue;
queue_idx_t page_idx;
logic [NUM_TABLES-1:0] lane_full;

function automatic queue_ctx_t put_field(queue_ctx_t ctx, table_sel_t sel, reg_word_t val);
    queue_ctx_t res;
    res = ctx;
    case (sel)
        TBL_TAIL:    res.tail = val;
        TBL_HEAD:    res.head = val;
        TBL_KMEM_LO: res.kmem_addr[31:0] = val;
        default:     res.kmem_addr[63:32] = val;
    endcase
    return res;
endfunction

assign page_idx = pcie_address[PAGE_LSB +: APP_IDX_WIDTH];

for (genvar i = 0; i < NUM_TABLES; i++) begin : g_lane
    assign lane_full[i] = &pcie_byteenable[4*i +: 4];
end

// during a start the requested queue is the one to protect
assign hit_queue = (state == IDLE && dma_start) ? {1'b0, dma_queue} : queue_id;

always_ff @(posedge pcie_clk) begin
    queue_ctx_t ctx_next;
    logic [NUM_TABLES-1:0] pend_next;

    ctx_next = f2c_ctx;
    pend_next = load_pend;
    rd_en_a <= '0;
    wr_en_a <= 1'b0;
    queue_ready <= 1'b0;

    if (!pcie_reset_n) begin
        state <= IDLE;
        queue_id <= '1;
        load_pend <= '0;
        f2c_ctx <= '0;
    end else begin
        case (state)
            IDLE: begin
                if (dma_start && queue_id != {1'b0, dma_queue}) begin
                    // a port B write from last cycle is taken directly
                    for (int i = 0; i < NUM_TABLES; i++) begin
                        if (wr_b[i].en && wr_b[i].addr == dma_queue) begin
                            ctx_next = put_field(ctx_next, table_sel_t'(i), wr_b[i].data);
                            pend_next[i] = 1'b0;
                        end else begin
                            pend_next[i] = 1'b1;
                        end
                    end
                    addr_a <= dma_queue;
                    rd_en_a <= pend_next;
                    queue_id <= {1'b0, dma_queue};
                    state <= BRAM_DELAY_1;
                end else if (dma_start) begin
                    // context already loaded
                    queue_ready <= 1'b1;
                    state <= WAIT_DMA;
                end
            end
            BRAM_DELAY_1: begin
                state <= BRAM_DELAY_2;
            end
            BRAM_DELAY_2: begin
                state <= SWITCH_QUEUE;
            end
            SWITCH_QUEUE: begin
                for (int i = 0; i < NUM_TABLES; i++) begin
                    if (load_pend[i]) begin
                        ctx_next = put_field(ctx_next, table_sel_t'(i), rd_data_a[i]);
                    end
                end
                pend_next = '0;
                queue_ready <= 1'b1;
                state <= WAIT_DMA;
            end
            WAIT_DMA: begin
                if (dma_done) begin
                    ctx_next.tail = new_tail;
                    addr_a <= queue_id[APP_IDX_WIDTH-1:0];
                    wr_data_a <= new_tail;
                    wr_en_a <= 1'b1;
                    state <= IDLE;
                end
            end
            default: begin
                state <= IDLE;
            end
        endcase

        // host writes to the active or loading queue override table data
        if (pcie_write && {1'b0, page_idx} == hit_queue) begin
            for (int i = 0; i < NUM_TABLES; i++) begin
                if (lane_full[i]) begin
                    ctx_next = put_field(ctx_next, table_sel_t'(i), pcie_writedata[32*i +: 32]);
                    pend_next[i] = 1'b0;
                end
            end
        end

        f2c_ctx <= ctx_next;
        load_pend <= pend_next;
    end
end

a_done_in_wait: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    dma_done |-> state == WAIT_DMA);

endmodule

/* rtl/port_b_arbiter.sv */
module port_b_arbiter
    import qctx_pkg::*;
#(
    parameter int PCIE_ADDR_WIDTH = 16
) (
    input  logic                         pcie_clk,
    input  logic                         pcie_reset_n,

    // host port 0
    input  logic [PCIE_ADDR_WIDTH-1:0]   pcie_address,
    input  logic                         pcie_write,
    input  logic                         pcie_read,
    input  logic [PCIE_DWIDTH-1:0]       pcie_writedata,
    input  logic [PCIE_DWIDTH/8-1:0]     pcie_byteenable,
    output logic [PCIE_DWIDTH-1:0]       pcie_readdata,
    output logic                         pcie_readdatavalid,

    // status table reads
    input  logic                         stat_rd_req,
    input  table_sel_t                   stat_rd_sel,
    input  queue_idx_t                   stat_rd_queue,
    output reg_word_t                    stat_rd_data,
    output logic                         stat_rd_valid,

    // port B of the four tables
    output table_wr_t [NUM_TABLES-1:0]   wr_b,
    output logic [NUM_TABLES-1:0]        rd_en_b,
    output queue_idx_t                   rd_addr_b,
    input  reg_word_t [NUM_TABLES-1:0]   rd_data_b
);

queue_idx_t page_idx;
logic [NUM_TABLES-1:0] lane_full;

// one-deep pending slots
logic host_pend;
queue_idx_t host_pend_q;
logic stat_pend;
queue_idx_t stat_pend_q;
table_sel_t stat_pend_sel;

logic serve_host;
logic serve_stat;

// requester and field delayed along with the two-cycle table read
logic host_rd_r1;
logic host_rd_r2;
logic stat_rd_r1;
logic stat_rd_r2;
table_sel_t sel_r1;
table_sel_t sel_r2;

reg_word_t [REG_LANES-1:0] rd_row;

assign page_idx = pcie_address[PAGE_LSB +: APP_IDX_WIDTH];

for (genvar i = 0; i < NUM_TABLES; i++) begin : g_lane
    assign lane_full[i] = &pcie_byteenable[4*i +: 4];
end

// host writes own the port and host reads go before status reads
assign serve_host = host_pend && !pcie_write;
assign serve_stat = stat_pend && !pcie_write && !host_pend;
assign rd_addr_b = serve_host ? host_pend_q : stat_pend_q;

always_comb begin
    rd_en_b = '0;
    if (serve_host) begin
        rd_en_b = '1;
    end else if (serve_stat) begin
        rd_en_b[stat_pend_sel] = 1'b1;
    end
end

always_ff @(posedge pcie_clk) begin
    for (int i = 0; i < NUM_TABLES; i++) begin
        wr_b[i].en <= pcie_write && lane_full[i];
        wr_b[i].addr <= page_idx;
        wr_b[i].data <= pcie_writedata[32*i +: 32];
    end

    if (!pcie_reset_n) begin
        for (int i = 0; i < NUM_TABLES; i++) begin
            wr_b[i].en <= 1'b0;
        end
        host_pend <= 1'b0;
        stat_pend <= 1'b0;
        host_rd_r1 <= 1'b0;
        host_rd_r2 <= 1'b0;
        stat_rd_r1 <= 1'b0;
        stat_rd_r2 <= 1'b0;
    end else begin
        if (serve_host) begin
            host_pend <= 1'b0;
        end
        if (pcie_read) begin
            host_pend <= 1'b1;
            host_pend_q <= page_idx;
        end

        if (serve_stat) begin
            stat_pend <= 1'b0;
        end
        if (stat_rd_req) begin
            stat_pend <= 1'b1;
            stat_pend_q <= stat_rd_queue;
            stat_pend_sel <= stat_rd_sel;
        end

        host_rd_r1 <= serve_host;
        host_rd_r2 <= host_rd_r1;
        stat_rd_r1 <= serve_stat;
        stat_rd_r2 <= stat_rd_r1;
    end

    sel_r1 <= stat_pend_sel;
    sel_r2 <= sel_r1;
end

// rows 0 to 3 carry the four fields and the rest reads as zero
always_comb begin
    rd_row = '0;
    for (int i = 0; i < NUM_TABLES; i++) begin
        rd_row[i] = rd_data_b[i];
    end
end

assign pcie_readdata = rd_row;
assign pcie_readdatavalid = host_rd_r2;

assign stat_rd_data = rd_data_b[sel_r2];
assign stat_rd_valid = stat_rd_r2;

// a new host read only after the last read data, or the one-deep slot is lost
a_host_rd_single: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    pcie_read |-> !host_pend && !host_rd_r1 && !pcie_readdatavalid);

endmodule

/* rtl/queue_table_ram.sv */
module queue_table_ram
    import qctx_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic       pcie_clk,

    // port A, used by the queue switch FSM
    input  queue_idx_t addr_a,
    input  logic       rd_en_a,
    input  logic       wr_en_a,
    input  reg_word_t  wr_data_a,
    output reg_word_t  rd_data_a,

    // port B, shared by host and status accesses
    input  table_wr_t  wr_b,
    input  logic       rd_en_b,
    input  queue_idx_t rd_addr_b,
    output reg_word_t  rd_data_b
);

reg_word_t mem [DEPTH];
reg_word_t q_a;
reg_word_t q_b;

always_ff @(posedge pcie_clk) begin
    if (wr_en_a) begin
        mem[addr_a] <= wr_data_a;
    end
    // port B last, so a host write wins over a tail write-back
    if (wr_b.en) begin
        mem[wr_b.addr] <= wr_b.data;
    end
    if (rd_en_a) begin
        q_a <= mem[addr_a];
    end
    if (rd_en_b) begin
        q_b <= mem[rd_addr_b];
    end
    // output register, data valid two cycles after the read enable
    rd_data_a <= q_a;
    rd_data_b <= q_b;
end

// the FSM loads and writes back in different states
a_port_a_excl: assert property (@(posedge pcie_clk) !(rd_en_a && wr_en_a));

endmodule

/* rtl/qctx_pkg.sv */
package qctx_pkg;

// queue index width, 16 queues
localparam int APP_IDX_WIDTH = 4;
localparam int NUM_TABLES = 4;

// host port 0 bus
localparam int PCIE_DWIDTH = 512;
localparam int REG_LANES = 16;
// lowest bit of the page index in the byte address
localparam int PAGE_LSB = 12;

// status bus
localparam int STAT_ADDR_WIDTH = 30;
localparam int CTRL_ADDR = 0;

// control register fields
localparam int DISABLE_BIT = 0;
localparam int RB_SIZE_LSB = 1;
localparam int RB_SIZE_WIDTH = 26;

typedef logic [31:0] reg_word_t;
typedef logic [APP_IDX_WIDTH-1:0] queue_idx_t;

// table field, also the 32-bit lane of that field in a host word
typedef enum logic [1:0] {
    TBL_TAIL,
    TBL_HEAD,
    TBL_KMEM_LO,
    TBL_KMEM_HI
} table_sel_t;

// context of the active queue as seen by the DMA engine
typedef struct packed {
    reg_word_t   tail;
    reg_word_t   head;
    logic [63:0] kmem_addr;
} queue_ctx_t;

// one port B write strobe for one table
typedef struct packed {
    logic       en;
    queue_idx_t addr;
    reg_word_t  data;
} table_wr_t;

endpackage
